// ==== verilog/mesh_pkg.sv ====
package mesh_pkg;

  // one coordinate field, enough for an 8 by 8 mesh
  localparam int coord_width_c = 3;

  // router ports, also the result of a routing decision
  // east is spelled out since dir_e already names the type
  typedef enum logic [2:0] {
    dir_p    = 3'd0,
    dir_w    = 3'd1,
    dir_east = 3'd2,
    dir_n    = 3'd3,
    dir_s    = 3'd4
  } dir_e;

  localparam int num_dirs_c = 5;

  // flit layout, msb first: src_x, src_y, dst_x, dst_y, data
  // coordinate slots sit above the data word, counted upward
  localparam int dst_y_slot_c = 0;
  localparam int dst_x_slot_c = 1;
  localparam int src_y_slot_c = 2;
  localparam int src_x_slot_c = 3;

  function automatic int flit_width_f(input int data_width);
    return 4 * coord_width_c + data_width;
  endfunction

  // lsb of one coordinate slot inside a flit
  function automatic int coord_lsb_f(input int data_width, input int slot);
    return data_width + slot * coord_width_c;
  endfunction

endpackage

// ==== verilog/mesh_fifo.sv ====
`timescale 1ns/10ps

module mesh_fifo #(
  parameter int data_width_p = 32,
  localparam int flit_w_lp = mesh_pkg::flit_width_f(data_width_p)
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [flit_w_lp-1:0] in_flit_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [flit_w_lp-1:0] out_flit_o
);

  logic [flit_w_lp-1:0] mem_q [2];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [1:0]           count_q;
  logic                 push;
  logic                 pop;

  // ready while a slot is free, so a steady stream sits at one entry
  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_flit_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop)
      begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // a flit offered to a full buffer has to wait, nothing gets written over
  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_flit_i));

endmodule

// ==== verilog/mesh_router.sv ====
`timescale 1ns/10ps

module mesh_router #(
  parameter int num_x_p = 2,
  parameter int num_y_p = 2,
  parameter int data_width_p = 32,
  localparam int flit_w_lp = mesh_pkg::flit_width_f(data_width_p),
  localparam int cw_lp = mesh_pkg::coord_width_c,
  localparam int nd_lp = mesh_pkg::num_dirs_c
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [cw_lp-1:0]                my_x_i,
  input  logic [cw_lp-1:0]                my_y_i,
  input  logic [nd_lp-1:0]                link_valid_i,
  output logic [nd_lp-1:0]                link_ready_o,
  input  logic [nd_lp-1:0][flit_w_lp-1:0] link_flit_i,
  output logic [nd_lp-1:0]                link_valid_o,
  input  logic [nd_lp-1:0]                link_ready_i,
  output logic [nd_lp-1:0][flit_w_lp-1:0] link_flit_o
);

  localparam int dst_x_lsb_lp = mesh_pkg::coord_lsb_f(data_width_p, mesh_pkg::dst_x_slot_c);
  localparam int dst_y_lsb_lp = mesh_pkg::coord_lsb_f(data_width_p, mesh_pkg::dst_y_slot_c);

  logic [nd_lp-1:0]                head_valid;
  logic [nd_lp-1:0]                head_pop;
  logic [nd_lp-1:0][flit_w_lp-1:0] head_flit;
  mesh_pkg::dir_e                  route [nd_lp];
  // indexed [output][input]
  logic [nd_lp-1:0][nd_lp-1:0]     req;
  logic [nd_lp-1:0][2:0]           grant;
  logic [nd_lp-1:0][2:0]           last_q;
  logic [nd_lp-1:0][2:0]           held_q;
  logic [nd_lp-1:0]                locked_q;

  // first requester after the last winner
  function automatic logic [2:0] rr_pick(input logic [nd_lp-1:0] req_v, input logic [2:0] last);
    logic [2:0] pick;
    int         idx;
    pick = last;
    for (int k = nd_lp; k >= 1; k--)
    begin
      idx = (int'(last) + k) % nd_lp;
      if (req_v[idx])
        pick = 3'(idx);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < nd_lp; i++)
  begin : g_in
    mesh_fifo #(
      .data_width_p(data_width_p)
    ) i_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_valid_i (link_valid_i[i]),
      .in_ready_o (link_ready_o[i]),
      .in_flit_i  (link_flit_i[i]),
      .out_valid_o(head_valid[i]),
      .out_ready_i(head_pop[i]),
      .out_flit_o (head_flit[i])
    );
  end

  // dimension order: settle x first, then y
  always_comb
  begin : p_route
    logic [cw_lp-1:0] dx;
    logic [cw_lp-1:0] dy;
    for (int i = 0; i < nd_lp; i++)
    begin
      dx = head_flit[i][dst_x_lsb_lp +: cw_lp];
      dy = head_flit[i][dst_y_lsb_lp +: cw_lp];
      if (dx > my_x_i)
        route[i] = mesh_pkg::dir_east;
      else if (dx < my_x_i)
        route[i] = mesh_pkg::dir_w;
      else if (dy > my_y_i)
        route[i] = mesh_pkg::dir_s;
      else if (dy < my_y_i)
        route[i] = mesh_pkg::dir_n;
      else
        route[i] = mesh_pkg::dir_p;
      for (int o = 0; o < nd_lp; o++)
        req[o][i] = head_valid[i] && (int'(route[i]) == o);
    end
  end

  // a stalled output keeps its winner so the flit stays put
  always_comb
  begin
    head_pop = '0;
    for (int o = 0; o < nd_lp; o++)
    begin
      grant[o]        = locked_q[o] ? held_q[o] : rr_pick(req[o], last_q[o]);
      link_valid_o[o] = req[o][grant[o]];
      link_flit_o[o]  = head_flit[grant[o]];
      if (link_valid_o[o] && link_ready_i[o])
        head_pop[grant[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      locked_q <= '0;
      held_q   <= '0;
      last_q   <= '0;
    end
    else
    begin
      for (int o = 0; o < nd_lp; o++)
      begin
        locked_q[o] <= link_valid_o[o] && !link_ready_i[o];
        held_q[o]   <= grant[o];
        if (link_valid_o[o] && link_ready_i[o])
          last_q[o] <= grant[o];
      end
    end
  end

  // x travel never turns back, and y travel never leaves its column
  a_dim_order: assert property (@(posedge clk_i) disable iff (rst_i)
    (!head_valid[mesh_pkg::dir_w] || route[mesh_pkg::dir_w] != mesh_pkg::dir_w) &&
    (!head_valid[mesh_pkg::dir_east] || route[mesh_pkg::dir_east] != mesh_pkg::dir_east) &&
    (!head_valid[mesh_pkg::dir_n] ||
      route[mesh_pkg::dir_n] inside {mesh_pkg::dir_s, mesh_pkg::dir_p}) &&
    (!head_valid[mesh_pkg::dir_s] ||
      route[mesh_pkg::dir_s] inside {mesh_pkg::dir_n, mesh_pkg::dir_p}));

  for (genvar o = 0; o < nd_lp; o++)
  begin : g_chk
    a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      link_valid_o[o] && !link_ready_i[o] |=> link_valid_o[o] && $stable(link_flit_o[o]));

    a_dst_in_mesh: assert property (@(posedge clk_i) disable iff (rst_i)
      head_valid[o] |-> head_flit[o][dst_x_lsb_lp +: cw_lp] < num_x_p &&
        head_flit[o][dst_y_lsb_lp +: cw_lp] < num_y_p);
  end

endmodule

// ==== verilog/mesh_injector.sv ====
`timescale 1ns/10ps

module mesh_injector #(
  parameter int num_x_p = 2,
  parameter int num_y_p = 2,
  parameter int data_width_p = 32,
  localparam int flit_w_lp = mesh_pkg::flit_width_f(data_width_p),
  localparam int cw_lp = mesh_pkg::coord_width_c,
  localparam int tiles_lp = num_x_p * num_y_p
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               in_valid_i,
  output logic                               in_ready_o,
  input  logic [cw_lp-1:0]                   in_src_x_i,
  input  logic [cw_lp-1:0]                   in_src_y_i,
  input  logic [cw_lp-1:0]                   in_dst_x_i,
  input  logic [cw_lp-1:0]                   in_dst_y_i,
  input  logic [data_width_p-1:0]            in_data_i,
  output logic [tiles_lp-1:0]                tile_valid_o,
  output logic [tiles_lp-1:0][flit_w_lp-1:0] tile_flit_o,
  input  logic [tiles_lp-1:0]                tile_ready_i
);

  localparam int src_x_lsb_lp = mesh_pkg::coord_lsb_f(data_width_p, mesh_pkg::src_x_slot_c);
  localparam int src_y_lsb_lp = mesh_pkg::coord_lsb_f(data_width_p, mesh_pkg::src_y_slot_c);

  logic                 live_q;
  logic                 valid_q;
  logic [flit_w_lp-1:0] flit_q;
  logic [tiles_lp-1:0]  sel;
  logic                 push;
  logic                 pop;

  // one-hot source tile of the held flit
  always_comb
  begin
    for (int t = 0; t < tiles_lp; t++)
      sel[t] = (int'(flit_q[src_y_lsb_lp +: cw_lp]) * num_x_p +
                int'(flit_q[src_x_lsb_lp +: cw_lp])) == t;
  end

  assign tile_valid_o = sel & {tiles_lp{valid_q}};
  assign tile_flit_o  = {tiles_lp{flit_q}};
  assign pop          = valid_q && |(sel & tile_ready_i);
  // live_q keeps the host side closed until the first cycle out of reset
  assign in_ready_o   = live_q && (!valid_q || pop);
  assign push         = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      live_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      live_q <= 1'b1;
      if (push)
        valid_q <= 1'b1;
      else if (pop)
        valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      flit_q <= {in_src_x_i, in_src_y_i, in_dst_x_i, in_dst_y_i, in_data_i};
    end
  end

  a_src_in_mesh: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && in_ready_o |-> in_src_x_i < num_x_p && in_src_y_i < num_y_p);

endmodule

// ==== verilog/mesh_collector.sv ====
`timescale 1ns/10ps

module mesh_collector #(
  parameter int num_x_p = 2,
  parameter int num_y_p = 2,
  parameter int data_width_p = 32,
  localparam int flit_w_lp = mesh_pkg::flit_width_f(data_width_p),
  localparam int cw_lp = mesh_pkg::coord_width_c,
  localparam int tiles_lp = num_x_p * num_y_p,
  localparam int idx_w_lp = $clog2(tiles_lp)
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [tiles_lp-1:0]                tile_valid_i,
  input  logic [tiles_lp-1:0][flit_w_lp-1:0] tile_flit_i,
  output logic [tiles_lp-1:0]                tile_ready_o,
  output logic                               out_valid_o,
  input  logic                               out_ready_i,
  output logic [cw_lp-1:0]                   out_src_x_o,
  output logic [cw_lp-1:0]                   out_src_y_o,
  output logic [cw_lp-1:0]                   out_dst_x_o,
  output logic [cw_lp-1:0]                   out_dst_y_o,
  output logic [data_width_p-1:0]            out_data_o,
  output logic [cw_lp-1:0]                   out_tile_x_o,
  output logic [cw_lp-1:0]                   out_tile_y_o
);

  logic                 valid_q;
  logic [flit_w_lp-1:0] flit_q;
  logic [cw_lp-1:0]     tile_x_q;
  logic [cw_lp-1:0]     tile_y_q;
  logic [idx_w_lp-1:0]  last_q;
  logic [idx_w_lp-1:0]  grant;
  logic [cw_lp-1:0]     grant_x;
  logic [cw_lp-1:0]     grant_y;
  logic                 free;
  logic                 take;

  // the output register takes a new flit when empty or draining
  assign free = !valid_q || out_ready_i;
  assign take = free && |tile_valid_i;

  always_comb
  begin : p_arb
    int idx;
    grant   = last_q;
    grant_x = '0;
    grant_y = '0;
    for (int k = tiles_lp; k >= 1; k--)
    begin
      idx = (int'(last_q) + k) % tiles_lp;
      if (tile_valid_i[idx])
        grant = idx_w_lp'(idx);
    end
    for (int t = 0; t < tiles_lp; t++)
    begin
      tile_ready_o[t] = take && (int'(grant) == t);
      if (int'(grant) == t)
      begin
        grant_x = cw_lp'(t % num_x_p);
        grant_y = cw_lp'(t / num_x_p);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      valid_q <= 1'b0;
      last_q  <= '0;
    end
    else
    begin
      if (free)
        valid_q <= |tile_valid_i;
      if (take)
        last_q <= grant;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      flit_q   <= tile_flit_i[grant];
      tile_x_q <= grant_x;
      tile_y_q <= grant_y;
    end
  end

  assign out_valid_o  = valid_q;
  assign {out_src_x_o, out_src_y_o, out_dst_x_o, out_dst_y_o, out_data_o} = flit_q;
  assign out_tile_x_o = tile_x_q;
  assign out_tile_y_o = tile_y_q;

  // routing must have delivered each flit at its destination tile
  a_right_tile: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> out_dst_x_o == out_tile_x_o && out_dst_y_o == out_tile_y_o);

endmodule

// ==== verilog/mesh_top.sv ====
`timescale 1ns/10ps

module mesh_top #(
  parameter int num_x_p = 3,
  parameter int num_y_p = 3,
  parameter int data_width_p = 32,
  localparam int flit_w_lp = mesh_pkg::flit_width_f(data_width_p),
  localparam int cw_lp = mesh_pkg::coord_width_c
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  logic [cw_lp-1:0]        in_src_x_i,
  input  logic [cw_lp-1:0]        in_src_y_i,
  input  logic [cw_lp-1:0]        in_dst_x_i,
  input  logic [cw_lp-1:0]        in_dst_y_i,
  input  logic [data_width_p-1:0] in_data_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic [cw_lp-1:0]        out_src_x_o,
  output logic [cw_lp-1:0]        out_src_y_o,
  output logic [cw_lp-1:0]        out_dst_x_o,
  output logic [cw_lp-1:0]        out_dst_y_o,
  output logic [data_width_p-1:0] out_data_o,
  output logic [cw_lp-1:0]        out_tile_x_o,
  output logic [cw_lp-1:0]        out_tile_y_o
);

  localparam int tiles_lp = num_x_p * num_y_p;
  localparam int nd_lp = mesh_pkg::num_dirs_c;

  logic [tiles_lp-1:0]                           inj_valid;
  logic [tiles_lp-1:0]                           inj_ready;
  logic [tiles_lp-1:0][flit_w_lp-1:0]            inj_flit;
  logic [tiles_lp-1:0]                           col_valid;
  logic [tiles_lp-1:0]                           col_ready;
  logic [tiles_lp-1:0][flit_w_lp-1:0]            col_flit;
  // per tile and port, named from the router side
  logic [tiles_lp-1:0][nd_lp-1:0]                lv_in;
  logic [tiles_lp-1:0][nd_lp-1:0]                lr_out;
  logic [tiles_lp-1:0][nd_lp-1:0][flit_w_lp-1:0] lf_in;
  logic [tiles_lp-1:0][nd_lp-1:0]                lv_out;
  logic [tiles_lp-1:0][nd_lp-1:0]                lr_in;
  logic [tiles_lp-1:0][nd_lp-1:0][flit_w_lp-1:0] lf_out;

  mesh_injector #(
    .num_x_p     (num_x_p),
    .num_y_p     (num_y_p),
    .data_width_p(data_width_p)
  ) i_injector (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_src_x_i  (in_src_x_i),
    .in_src_y_i  (in_src_y_i),
    .in_dst_x_i  (in_dst_x_i),
    .in_dst_y_i  (in_dst_y_i),
    .in_data_i   (in_data_i),
    .tile_valid_o(inj_valid),
    .tile_flit_o (inj_flit),
    .tile_ready_i(inj_ready)
  );

  for (genvar y = 0; y < num_y_p; y++)
  begin : g_y
    for (genvar x = 0; x < num_x_p; x++)
    begin : g_x
      localparam int t_lp = y * num_x_p + x;

      mesh_router #(
        .num_x_p     (num_x_p),
        .num_y_p     (num_y_p),
        .data_width_p(data_width_p)
      ) i_router (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .my_x_i      (cw_lp'(x)),
        .my_y_i      (cw_lp'(y)),
        .link_valid_i(lv_in[t_lp]),
        .link_ready_o(lr_out[t_lp]),
        .link_flit_i (lf_in[t_lp]),
        .link_valid_o(lv_out[t_lp]),
        .link_ready_i(lr_in[t_lp]),
        .link_flit_o (lf_out[t_lp])
      );

      // local port to the host side
      assign lv_in[t_lp][mesh_pkg::dir_p] = inj_valid[t_lp];
      assign lf_in[t_lp][mesh_pkg::dir_p] = inj_flit[t_lp];
      assign inj_ready[t_lp]              = lr_out[t_lp][mesh_pkg::dir_p];
      assign col_valid[t_lp]              = lv_out[t_lp][mesh_pkg::dir_p];
      assign col_flit[t_lp]               = lf_out[t_lp][mesh_pkg::dir_p];
      assign lr_in[t_lp][mesh_pkg::dir_p] = col_ready[t_lp];

      // each tile drives its own inputs and the ready of its own outputs
      if (x > 0)
      begin : g_w
        assign lv_in[t_lp][mesh_pkg::dir_w] = lv_out[t_lp-1][mesh_pkg::dir_east];
        assign lf_in[t_lp][mesh_pkg::dir_w] = lf_out[t_lp-1][mesh_pkg::dir_east];
        assign lr_in[t_lp][mesh_pkg::dir_w] = lr_out[t_lp-1][mesh_pkg::dir_east];
      end
      else
      begin : g_w_edge
        assign lv_in[t_lp][mesh_pkg::dir_w] = 1'b0;
        assign lf_in[t_lp][mesh_pkg::dir_w] = '0;
        assign lr_in[t_lp][mesh_pkg::dir_w] = 1'b1;
      end

      if (x < num_x_p - 1)
      begin : g_e
        assign lv_in[t_lp][mesh_pkg::dir_east] = lv_out[t_lp+1][mesh_pkg::dir_w];
        assign lf_in[t_lp][mesh_pkg::dir_east] = lf_out[t_lp+1][mesh_pkg::dir_w];
        assign lr_in[t_lp][mesh_pkg::dir_east] = lr_out[t_lp+1][mesh_pkg::dir_w];
      end
      else
      begin : g_e_edge
        assign lv_in[t_lp][mesh_pkg::dir_east] = 1'b0;
        assign lf_in[t_lp][mesh_pkg::dir_east] = '0;
        assign lr_in[t_lp][mesh_pkg::dir_east] = 1'b1;
      end

      if (y > 0)
      begin : g_n
        assign lv_in[t_lp][mesh_pkg::dir_n] = lv_out[t_lp-num_x_p][mesh_pkg::dir_s];
        assign lf_in[t_lp][mesh_pkg::dir_n] = lf_out[t_lp-num_x_p][mesh_pkg::dir_s];
        assign lr_in[t_lp][mesh_pkg::dir_n] = lr_out[t_lp-num_x_p][mesh_pkg::dir_s];
      end
      else
      begin : g_n_edge
        assign lv_in[t_lp][mesh_pkg::dir_n] = 1'b0;
        assign lf_in[t_lp][mesh_pkg::dir_n] = '0;
        assign lr_in[t_lp][mesh_pkg::dir_n] = 1'b1;
      end

      if (y < num_y_p - 1)
      begin : g_s
        assign lv_in[t_lp][mesh_pkg::dir_s] = lv_out[t_lp+num_x_p][mesh_pkg::dir_n];
        assign lf_in[t_lp][mesh_pkg::dir_s] = lf_out[t_lp+num_x_p][mesh_pkg::dir_n];
        assign lr_in[t_lp][mesh_pkg::dir_s] = lr_out[t_lp+num_x_p][mesh_pkg::dir_n];
      end
      else
      begin : g_s_edge
        assign lv_in[t_lp][mesh_pkg::dir_s] = 1'b0;
        assign lf_in[t_lp][mesh_pkg::dir_s] = '0;
        assign lr_in[t_lp][mesh_pkg::dir_s] = 1'b1;
      end
    end
  end

  mesh_collector #(
    .num_x_p     (num_x_p),
    .num_y_p     (num_y_p),
    .data_width_p(data_width_p)
  ) i_collector (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tile_valid_i(col_valid),
    .tile_flit_i (col_flit),
    .tile_ready_o(col_ready),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_src_x_o (out_src_x_o),
    .out_src_y_o (out_src_y_o),
    .out_dst_x_o (out_dst_x_o),
    .out_dst_y_o (out_dst_y_o),
    .out_data_o  (out_data_o),
    .out_tile_x_o(out_tile_x_o),
    .out_tile_y_o(out_tile_y_o)
  );

endmodule

// ==== test/mesh_tb.sv ====
`timescale 1ns/10ps

module mesh_tb;

  localparam int num_x_lp      = 3;
  localparam int num_y_lp      = 3;
  localparam int data_width_lp = 32;
  localparam int tiles_lp      = num_x_lp * num_y_lp;
  localparam int pairs_lp      = tiles_lp * tiles_lp;
  localparam int cw_lp         = mesh_pkg::coord_width_c;
  localparam int wait_limit_lp = 4000;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     in_valid_i;
  logic                     in_ready_o;
  logic [cw_lp-1:0]         in_src_x_i;
  logic [cw_lp-1:0]         in_src_y_i;
  logic [cw_lp-1:0]         in_dst_x_i;
  logic [cw_lp-1:0]         in_dst_y_i;
  logic [data_width_lp-1:0] in_data_i;
  logic                     out_valid_o;
  logic                     out_ready_i;
  logic [cw_lp-1:0]         out_src_x_o;
  logic [cw_lp-1:0]         out_src_y_o;
  logic [cw_lp-1:0]         out_dst_x_o;
  logic [cw_lp-1:0]         out_dst_y_o;
  logic [data_width_lp-1:0] out_data_o;
  logic [cw_lp-1:0]         out_tile_x_o;
  logic [cw_lp-1:0]         out_tile_y_o;

  // scoreboard, one queue of payloads per source and destination pair
  logic [data_width_lp-1:0] sb_q [pairs_lp][$];
  int                       pending = 0;
  int                       cyc = 0;
  logic                     stall_en = 1'b0;
  int                       stall_pct = 0;
  logic                     exp_avail = 1'b0;
  logic [data_width_lp-1:0] exp_data = '0;
  logic                     stall_q;
  logic [6*cw_lp+data_width_lp-1:0] out_bus;
  logic [6*cw_lp+data_width_lp-1:0] held_bus_q;

  mesh_top #(
    .num_x_p     (num_x_lp),
    .num_y_p     (num_y_lp),
    .data_width_p(data_width_lp)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_src_x_i  (in_src_x_i),
    .in_src_y_i  (in_src_y_i),
    .in_dst_x_i  (in_dst_x_i),
    .in_dst_y_i  (in_dst_y_i),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_src_x_o (out_src_x_o),
    .out_src_y_o (out_src_y_o),
    .out_dst_x_o (out_dst_x_o),
    .out_dst_y_o (out_dst_y_o),
    .out_data_o  (out_data_o),
    .out_tile_x_o(out_tile_x_o),
    .out_tile_y_o(out_tile_y_o)
  );

  always #4 clk_i = ~clk_i;

  assign out_bus = {out_src_x_o, out_src_y_o, out_dst_x_o, out_dst_y_o, out_data_o,
                    out_tile_x_o, out_tile_y_o};

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // tiles are numbered row by row from the north west corner
  function automatic int pair_index(input logic [cw_lp-1:0] sx, input logic [cw_lp-1:0] sy,
                                    input logic [cw_lp-1:0] dx, input logic [cw_lp-1:0] dy);
    return (int'(sy) * num_x_lp + int'(sx)) * tiles_lp + int'(dy) * num_x_lp + int'(dx);
  endfunction

  always @(posedge clk_i)
  begin
    cyc        <= cyc + 1;
    stall_q    <= out_valid_o && !out_ready_i;
    held_bus_q <= out_bus;
  end

  always @(posedge clk_i)
  begin : p_scoreboard
    int pair;
    if (!rst_i && in_valid_i && in_ready_o)
    begin
      pair = pair_index(in_src_x_i, in_src_y_i, in_dst_x_i, in_dst_y_i);
      sb_q[pair].push_back(in_data_i);
      pending = pending + 1;
    end
    if (!rst_i && out_valid_o && out_ready_i)
    begin
      pair = pair_index(out_src_x_o, out_src_y_o, out_dst_x_o, out_dst_y_o);
      if (pair < pairs_lp && sb_q[pair].size() > 0)
      begin
        void'(sb_q[pair].pop_front());
        pending = pending - 1;
      end
    end
  end

  // head of the queue for the flit now at the output, settled before the next edge
  always @(negedge clk_i)
  begin : p_expect
    int pair;
    exp_avail <= 1'b0;
    if (out_valid_o === 1'b1)
    begin
      pair = pair_index(out_src_x_o, out_src_y_o, out_dst_x_o, out_dst_y_o);
      if (pair < pairs_lp && sb_q[pair].size() > 0)
      begin
        exp_avail <= 1'b1;
        exp_data  <= sb_q[pair][0];
      end
    end
  end

  // random gaps on the host output
  always @(negedge clk_i)
  begin
    if (rst_i || !stall_en)
      out_ready_i <= 1'b1;
    else
      out_ready_i <= int'($urandom % 100) >= stall_pct;
  end

  a_reset_quiet: assert property (@(posedge clk_i) cyc > 0 && rst_i |->
    !out_valid_o && !in_ready_o)
    else fail_run("out_valid_o or in_ready_o was high during reset");

  a_ready_after_reset: assert property (@(posedge clk_i) $fell(rst_i) |->
    !out_valid_o && !in_ready_o ##1 in_ready_o)
    else fail_run("in_ready_o did not rise in the first cycle after reset");

  a_tile_is_dst: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> out_tile_x_o == out_dst_x_o && out_tile_y_o == out_dst_y_o)
    else fail_run($sformatf("ERROR out_tile_x_o/out_tile_y_o 0x%h/0x%h, expected 0x%h/0x%h",
      $sampled(out_tile_x_o), $sampled(out_tile_y_o),
      $sampled(out_dst_x_o), $sampled(out_dst_y_o)));

  a_flit_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i |-> exp_avail)
    else fail_run("a flit left the mesh that was never sent or was already delivered");

  a_data_matches: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && exp_avail |-> out_data_o == exp_data)
    else fail_run($sformatf("ERROR out_data_o 0x%h, expected 0x%h",
      $sampled(out_data_o), $sampled(exp_data)));

  a_hold_under_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_q |-> out_valid_o && out_bus == held_bus_q)
    else fail_run($sformatf("ERROR out_valid_o 0x%h out fields 0x%h, expected 0x1 0x%h",
      $sampled(out_valid_o), $sampled(out_bus), $sampled(held_bus_q)));

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_packet(input int sx, input int sy, input int dx, input int dy,
                             input logic [data_width_lp-1:0] data);
    int waited;
    waited     = 0;
    in_valid_i = 1'b1;
    in_src_x_i = cw_lp'(sx);
    in_src_y_i = cw_lp'(sy);
    in_dst_x_i = cw_lp'(dx);
    in_dst_y_i = cw_lp'(dy);
    in_data_i  = data;
    while (!in_ready_o && waited < wait_limit_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (in_ready_o)
    begin
      @(negedge clk_i);
      in_valid_i = 1'b0;
    end
    else
      fail_run("timed out waiting for in_ready_o");
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending != 0 && waited < wait_limit_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (pending != 0)
      fail_run($sformatf("timed out with %0d packets still in the mesh", pending));
  endtask

  initial
  begin
    void'($urandom(32'h96c4_1b63));
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    in_src_x_i  = '0;
    in_src_y_i  = '0;
    in_dst_x_i  = '0;
    in_dst_y_i  = '0;
    in_data_i   = '0;
    out_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // every tile sends to itself
    for (int t = 0; t < tiles_lp; t++)
      send_packet(t % num_x_lp, t / num_x_lp, t % num_x_lp, t / num_x_lp, $urandom);
    wait_drain();

    // random traffic with output stalls
    stall_en  = 1'b1;
    stall_pct = 30;
    repeat (300)
    begin
      send_packet($urandom % num_x_lp, $urandom % num_y_lp,
                  $urandom % num_x_lp, $urandom % num_y_lp, $urandom);
      if ($urandom % 8 == 0)
        @(negedge clk_i);
    end
    wait_drain();

    // hotspot, all tiles aim at the centre
    stall_pct = 50;
    repeat (200)
      send_packet($urandom % num_x_lp, $urandom % num_y_lp, 1, 1, $urandom);
    wait_drain();

    stall_en = 1'b0;
    repeat (4) @(negedge clk_i);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/mesh_pkg.sv
verilog/mesh_fifo.sv
verilog/mesh_router.sv
verilog/mesh_injector.sv
verilog/mesh_collector.sv
verilog/mesh_top.sv
test/mesh_tb.sv

// ==== Bender.yml ====
package:
  name: mesh_noc

sources:
  - verilog/mesh_pkg.sv
  - verilog/mesh_fifo.sv
  - verilog/mesh_router.sv
  - verilog/mesh_injector.sv
  - verilog/mesh_collector.sv
  - verilog/mesh_top.sv
  - target: test
    files:
      - test/mesh_tb.sv
